// ==== fsab_pkg.sv ====
package fsab_pkg;

	// kind of outbound request where the instruction cache only ever issues reads
	typedef enum logic [0:0] {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_e;

	typedef struct packed {
		fsab_mode_e  mode;   // read or write
		logic [3:0]  did;    // requesting device
		logic [3:0]  subdid; // unit inside the device
		logic [30:0] addr;   // byte address of the first beat
		logic [3:0]  len;    // number of 64-bit beats
		logic [63:0] data;   // write data, unused for reads
		logic [7:0]  mask;   // write byte enables
	} fsab_resp_t_unused_guard_placeholder;

	typedef fsab_resp_t_unused_guard_placeholder fsab_req_t;

	typedef struct packed {
		logic [3:0]  did;    // device that owns this beat
		logic [3:0]  subdid; // unit that owns this beat
		logic [63:0] data;   // one 64-bit beat of the line
	} fsab_resp_t;

	localparam logic [3:0] FSAB_DID_CPU = 4'd0;       // processor device id
	localparam logic [3:0] FSAB_SUBDID_ICACHE = 4'd1; // instruction cache sub-device id

	localparam int LINE_BEATS = 8; // 64-byte line in 64-bit beats
	localparam int IDX_W = 4;      // set index sits in address bits 9..6
	localparam int TAG_W = 22;     // tag sits in address bits 31..10

	// the miss machine is either waiting for a miss or collecting a line
	typedef enum logic [0:0] {
		MISS_IDLE = 1'b0,
		MISS_FILL = 1'b1
	} miss_state_e;

	// way number width that stays at one bit for a direct-mapped build
	function automatic int way_w(input int nways);
		return (nways > 1) ? $clog2(nways) : 1;
	endfunction

endpackage

// ==== icache_tags.sv ====
`timescale 1ns/10ps

module icache_tags import fsab_pkg::*; #(
	parameter int NWAYS = 2
) (
	input  logic                     clk,
	input  logic                     rst_b,
	input  logic [31:0]              rd_addr,
	input  logic                     fill_start,
	input  logic                     fill_done,
	input  logic [31:0]              fill_addr,
	output logic                     hit,
	output logic [way_w(NWAYS)-1:0] hit_way,
	output logic [way_w(NWAYS)-1:0] victim_way
);
	localparam int WAY_W = way_w(NWAYS);
	localparam int SETS = 1 << IDX_W;

	logic [NWAYS-1:0] valid_q [SETS];        // one valid bit per way in each set
	logic [TAG_W-1:0] tag_mem [SETS][NWAYS]; // stored tag of every way
	logic [WAY_W-1:0] rr_ptr_q [SETS];       // next way to replace in each set

	logic [IDX_W-1:0] rd_idx;
	logic [TAG_W-1:0] rd_tag;
	logic [IDX_W-1:0] fill_idx;
	logic [TAG_W-1:0] fill_tag;
	logic [NWAYS-1:0] hit_vec; // per-way match where at most one bit may be set

	assign rd_idx = rd_addr[IDX_W+5:6];    // set field of the fetch address
	assign rd_tag = rd_addr[31:32-TAG_W];  // tag field of the fetch address
	assign fill_idx = fill_addr[IDX_W+5:6]; // set being refilled
	assign fill_tag = fill_addr[31:32-TAG_W];

	// the way to replace is whatever the round-robin pointer of the fill set names
	assign victim_way = rr_ptr_q[fill_idx];

	always_comb begin
		hit_vec = '0;
		hit_way = '0;
		for (int w = 0; w < NWAYS; w++) begin
			if (valid_q[rd_idx][w] && (tag_mem[rd_idx][w] == rd_tag)) begin
				hit_vec[w] = 1'b1; // this way holds the fetched line
				hit_way = WAY_W'(w);
			end
		end
	end

	assign hit = |hit_vec; // any way matching is a hit

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			for (int s = 0; s < SETS; s++) begin
				valid_q[s] <= '0; // every line starts out empty
				rr_ptr_q[s] <= '0; // replacement starts at way 0
			end
		end else if (fill_start) begin
			valid_q[fill_idx][victim_way] <= 1'b0; // victim is about to be overwritten
		end else if (fill_done) begin
			valid_q[fill_idx][victim_way] <= 1'b1; // the new line is complete
			if (victim_way == WAY_W'(NWAYS - 1))
				rr_ptr_q[fill_idx] <= '0; // wrap back to the first way
			else
				rr_ptr_q[fill_idx] <= victim_way + 1'b1;
		end
	end

	// tag store written as the new line becomes valid
	always_ff @(posedge clk) begin
		if (fill_done)
			tag_mem[fill_idx][victim_way] <= fill_tag; // tag lands with the valid bit
	end

	// a line may only ever live in one way of its set
	a_single_way_hit: assert property (
		@(posedge clk) disable iff (!rst_b) $onehot0(hit_vec)
	) else $error("icache_tags: hit in more than one way of set %0d", rd_idx);

endmodule

// ==== icache_data.sv ====
`timescale 1ns/10ps

module icache_data import fsab_pkg::*; #(
	parameter int NWAYS = 2
) (
	input  logic                     clk,
	input  logic                     rst_b,
	input  logic [31:0]              rd_addr,
	input  logic [way_w(NWAYS)-1:0] hit_way,
	input  logic                     beat_we,
	input  logic [2:0]               beat_idx,
	input  logic [way_w(NWAYS)-1:0] victim_way,
	input  logic [31:0]              fill_addr,
	input  logic [63:0]              beat_data,
	output logic [31:0]              rd_data
);
	localparam int WAY_W = way_w(NWAYS);
	localparam int DEPTH = (1 << IDX_W) * LINE_BEATS;
	localparam int ADDR_W = IDX_W + 3;

	logic [NWAYS-1:0][63:0] data_mem [DEPTH]; // one row per set and beat with every way side by side
	logic [NWAYS-1:0][63:0] row_q;            // addressed beat of all ways
	logic [WAY_W-1:0] hit_way_q;              // way that hit in the address cycle
	logic word_sel_q;                         // address bit 2 picks the upper word

	logic [ADDR_W-1:0] rd_row;
	logic [ADDR_W-1:0] wr_row;
	logic [63:0] beat_sel;

	assign rd_row = rd_addr[IDX_W+5:3];                 // set and beat of the fetch
	assign wr_row = {fill_addr[IDX_W+5:6], beat_idx};   // set being filled and incoming beat

	always_ff @(posedge clk) begin
		if (beat_we)
			data_mem[wr_row][victim_way] <= beat_data; // each beat goes into the victim way
		row_q <= data_mem[rd_row]; // read every way and choose one a cycle later
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			hit_way_q <= '0;
			word_sel_q <= 1'b0;
		end else begin
			hit_way_q <= hit_way;
			word_sel_q <= rd_addr[2];
		end
	end

	assign beat_sel = row_q[hit_way_q];                              // beat of the way that hit
	assign rd_data = word_sel_q ? beat_sel[63:32] : beat_sel[31:0];  // little-endian word order

endmodule

// ==== icache_miss.sv ====
`timescale 1ns/10ps

module icache_miss import fsab_pkg::*; #(
	parameter int INIT_CREDITS = 2
) (
	input  logic        clk,
	input  logic        rst_b,
	input  logic        rd_req,
	input  logic [31:0] rd_addr,
	input  logic        hit,
	input  logic        bus_credit,
	input  logic        bus_resp_valid,
	input  fsab_resp_t  bus_resp,
	output logic        rd_wait,
	output logic        bus_req_valid,
	output fsab_req_t   bus_req,
	output logic        fill_start,
	output logic        fill_done,
	output logic [31:0] fill_addr,
	output logic        beat_we,
	output logic [2:0]  beat_idx,
	output logic [63:0] beat_data
);
	localparam int CRED_W = $clog2(INIT_CREDITS + 1);

	miss_state_e state_q;
	logic [CRED_W-1:0] credits_q; // credits currently owned
	logic [2:0] beat_cnt_q;       // beats of the line accepted so far
	logic done_q;                 // eighth beat seen and commit due this cycle
	logic [31:0] fill_addr_q;     // line address of the fill in flight
	logic start;
	logic ours;

	assign rd_wait = rd_req && !hit; // stall the fetch until the line is present

	// a miss leaves idle only while a credit is owned
	assign start = rd_wait && (state_q == MISS_IDLE) && (credits_q != '0);

	// beats for other devices or units are dropped here
	assign ours = bus_resp_valid && (bus_resp.did == FSAB_DID_CPU)
		&& (bus_resp.subdid == FSAB_SUBDID_ICACHE);

	assign beat_we = (state_q == MISS_FILL) && ours && !done_q;
	assign beat_idx = beat_cnt_q;
	assign beat_data = bus_resp.data;

	assign fill_start = start;   // tags drop the victim as the request leaves
	assign fill_done = done_q;   // tags commit one cycle after the last beat
	assign fill_addr = (state_q == MISS_IDLE) ? {rd_addr[31:6], 6'b0} : fill_addr_q;

	always_comb begin
		bus_req_valid = start;
		bus_req = '0;
		bus_req.mode = FSAB_READ;
		bus_req.did = FSAB_DID_CPU;
		bus_req.subdid = FSAB_SUBDID_ICACHE;
		bus_req.addr = {rd_addr[30:6], 6'b0}; // line aligned
		bus_req.len = 4'(LINE_BEATS);         // one beat per 8 bytes of line
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			credits_q <= CRED_W'(INIT_CREDITS);
		end else begin
			credits_q <= credits_q + CRED_W'(bus_credit) - CRED_W'(bus_req_valid);
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			state_q <= MISS_IDLE;
			beat_cnt_q <= '0;
			done_q <= 1'b0;
		end else begin
			case (state_q)
				MISS_IDLE: begin
					beat_cnt_q <= '0;
					if (start)
						state_q <= MISS_FILL;
				end
				MISS_FILL: begin
					if (done_q) begin
						done_q <= 1'b0;
						state_q <= MISS_IDLE; // line is valid from this edge on
					end else if (beat_we) begin
						beat_cnt_q <= beat_cnt_q + 3'd1;
						done_q <= (beat_cnt_q == 3'(LINE_BEATS - 1)); // last beat of the line
					end
				end
			endcase
		end
	end

	// line address of the miss, held while its beats arrive
	always_ff @(posedge clk) begin
		if (start)
			fill_addr_q <= {rd_addr[31:6], 6'b0};
	end

	// the bus must never hand back a credit that was not spent
	a_credit_bounds: assert property (
		@(posedge clk) disable iff (!rst_b)
		(credits_q <= CRED_W'(INIT_CREDITS))
		&& !(bus_credit && !bus_req_valid && (credits_q == CRED_W'(INIT_CREDITS)))
	) else $error("icache_miss: credit count %0d out of range", credits_q);

endmodule

// ==== icache_top.sv ====
`timescale 1ns/10ps

module icache_top import fsab_pkg::*; #(
	parameter int NWAYS = 2,
	parameter int INIT_CREDITS = 2
) (
	input  logic        clk,
	input  logic        rst_b,
	input  logic        rd_req,
	input  logic [31:0] rd_addr,
	input  logic        bus_credit,
	input  logic        bus_resp_valid,
	input  fsab_resp_t  bus_resp,
	output logic        rd_wait,
	output logic [31:0] rd_data,
	output logic        bus_req_valid,
	output fsab_req_t   bus_req
);
	localparam int WAY_W = way_w(NWAYS);

	logic hit;
	logic [WAY_W-1:0] hit_way;
	logic [WAY_W-1:0] victim_way;
	logic fill_start;
	logic fill_done;
	logic [31:0] fill_addr;
	logic beat_we;
	logic [2:0] beat_idx;
	logic [63:0] beat_data;

	// lookup and replacement bookkeeping
	icache_tags #(.NWAYS(NWAYS)) i_tags (
		.clk, .rst_b, .rd_addr, .fill_start, .fill_done, .fill_addr,
		.hit, .hit_way, .victim_way
	);

	// line storage with the registered fetch read
	icache_data #(.NWAYS(NWAYS)) i_data (
		.clk, .rst_b, .rd_addr, .hit_way, .beat_we, .beat_idx,
		.victim_way, .fill_addr, .beat_data, .rd_data
	);

	// credits, line request and beat collection
	icache_miss #(.INIT_CREDITS(INIT_CREDITS)) i_miss (
		.clk, .rst_b, .rd_req, .rd_addr, .hit, .bus_credit, .bus_resp_valid,
		.bus_resp, .rd_wait, .bus_req_valid, .bus_req, .fill_start, .fill_done,
		.fill_addr, .beat_we, .beat_idx, .beat_data
	);

endmodule

// ==== tb_icache.sv ====
`timescale 1ns/10ps

module tb_icache import fsab_pkg::*;;
	localparam int NWAYS = 2;
	localparam int INIT_CREDITS = 2;
	localparam int N_FETCH = 21;                 // fetches issued by the stimulus below
	localparam int WATCHDOG_CYCLES = 400 * N_FETCH;
	localparam logic [31:0] LINE_X = 32'h0000_0100; // set 4
	localparam logic [31:0] LINE_A = 32'h0000_1040; // A, B and C all map to set 1
	localparam logic [31:0] LINE_B = 32'h0000_2040;
	localparam logic [31:0] LINE_C = 32'h0000_3040;
	localparam logic [31:0] LINE_D = 32'h0000_0180; // D, E and F sit in sets 6, 7 and 8
	localparam logic [31:0] LINE_E = 32'h0000_01c0;
	localparam logic [31:0] LINE_F = 32'h0000_0200;

	logic clk = 1'b0;
	logic rst_b;
	logic rd_req;
	logic [31:0] rd_addr;
	logic rd_wait;
	logic [31:0] rd_data;
	logic bus_req_valid;
	fsab_req_t bus_req;
	logic bus_credit;
	logic bus_resp_valid;
	fsab_resp_t bus_resp;

	logic [31:0] cur_addr;     // address of the fetch in progress
	logic expect_hit;          // the fetch in progress should hit at once
	logic first_cycle;         // high during the first cycle of a fetch
	logic expect_stall;        // credits are withheld and the fetch must wait
	logic withhold;            // responder keeps credits instead of returning them
	logic accepted_q;          // fetch accepted on the last edge
	logic [31:0] addr_q;       // address of that fetch
	logic [7:0] req_total;     // line requests seen since reset
	logic [7:0] credit_total;  // credits handed back since reset
	logic [7:0] req_base;      // req_total when the current fetch started
	fsab_req_t req_log [256];  // every request, kept for the responder
	logic [15:0] lfsr_q;

	always #4 clk = ~clk;

	icache_top #(.NWAYS(NWAYS), .INIT_CREDITS(INIT_CREDITS)) i_dut (
		.clk, .rst_b, .rd_req, .rd_addr, .bus_credit, .bus_resp_valid, .bus_resp,
		.rd_wait, .rd_data, .bus_req_valid, .bus_req
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "stopped at the first error");
	endtask

	// upper word of a beat is its byte address and the lower word the inverse of it
	function automatic logic [31:0] model_word(input logic [31:0] addr);
		logic [31:0] beat_addr;
		beat_addr = {addr[31:3], 3'b000};
		return addr[2] ? beat_addr : ~beat_addr;
	endfunction

	// taps 16, 14, 13 and 11 give a maximal sequence
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
		lfsr_q = {lfsr_q[14:0], fb};
		return fb;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_step()}; // one step per bit taken
		return v;
	endfunction

	always @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			accepted_q <= 1'b0;
			addr_q <= '0;
			req_total <= '0;
			credit_total <= '0;
		end else begin
			accepted_q <= rd_req && !rd_wait; // data is due on the next edge
			addr_q <= rd_addr;
			if (bus_req_valid)
				req_total <= req_total + 8'd1;
			if (bus_credit)
				credit_total <= credit_total + 8'd1;
		end
	end

	always @(posedge clk) begin
		if (bus_req_valid)
			req_log[req_total] <= bus_req; // responder serves these in order
	end

	a_req_addr: assert property (@(posedge clk) disable iff (!rst_b)
		bus_req_valid |-> (bus_req.addr == {cur_addr[30:6], 6'b0})
	) else abort_run($sformatf("MISMATCH bus_req.addr got %h expected %h",
		bus_req.addr, {cur_addr[30:6], 6'b0}));

	a_req_kind: assert property (@(posedge clk) disable iff (!rst_b)
		bus_req_valid |-> (bus_req.mode == FSAB_READ && bus_req.len == 4'd8
			&& bus_req.did == FSAB_DID_CPU && bus_req.subdid == FSAB_SUBDID_ICACHE)
	) else abort_run($sformatf(
		"MISMATCH bus_req mode/len/did/subdid got %h/%h/%h/%h expected 0/8/0/1",
		bus_req.mode, bus_req.len, bus_req.did, bus_req.subdid));

	a_one_req: assert property (@(posedge clk) disable iff (!rst_b)
		bus_req_valid |-> (req_total == req_base)
	) else abort_run($sformatf("a second line request was sent for the fetch at %h", cur_addr));

	a_first_wait: assert property (@(posedge clk) disable iff (!rst_b)
		(rd_req && first_cycle) |-> (rd_wait == !expect_hit)
	) else abort_run($sformatf("MISMATCH rd_wait got %h expected %h for address %h",
		rd_wait, !expect_hit, cur_addr));

	a_req_count: assert property (@(posedge clk) disable iff (!rst_b)
		(rd_req && !rd_wait) |-> ((req_total - req_base) == (expect_hit ? 8'd0 : 8'd1))
	) else abort_run($sformatf("MISMATCH request count got %h expected %h for address %h",
		req_total - req_base, !expect_hit, cur_addr));

	a_rd_data: assert property (@(posedge clk) disable iff (!rst_b)
		accepted_q |-> (rd_data == model_word(addr_q))
	) else abort_run($sformatf("MISMATCH rd_data got %h expected %h for address %h",
		rd_data, model_word(addr_q), addr_q));

	a_outstanding: assert property (@(posedge clk) disable iff (!rst_b)
		(req_total - credit_total) <= 8'(INIT_CREDITS)
	) else abort_run("more line requests outstanding than the cache owns credits");

	a_stall: assert property (@(posedge clk) disable iff (!rst_b)
		expect_stall |-> (rd_wait && !bus_req_valid)
	) else abort_run("fetch went ahead while every credit was withheld");

	// bus model serving one line at a time with foreign beats mixed into the gaps
	initial begin : responder
		fsab_req_t r;
		logic [31:0] beat_addr;
		int served;
		int held;
		lfsr_q = 16'd16;
		served = 0;
		held = 0;
		bus_credit = 1'b0;
		bus_resp_valid = 1'b0;
		bus_resp = '0;
		forever begin
			@(negedge clk);
			bus_credit = 1'b0;
			if (held != 0 && !withhold) begin
				bus_credit = 1'b1; // hand back a kept credit
				held--;
			end else if (served < int'(req_total)) begin
				r = req_log[8'(served)];
				served++;
				repeat (rand_bits(3)) @(negedge clk);
				for (int b = 0; b < LINE_BEATS; b++) begin
					repeat (rand_bits(2)) begin
						bus_resp_valid = rand_bits(1) != 0; // maybe a beat for someone else
						bus_resp.did = 4'(rand_bits(1));
						if (bus_resp.did == FSAB_DID_CPU)
							bus_resp.subdid = 4'd2 + 4'(rand_bits(2)); // another unit of the processor
						else
							bus_resp.subdid = FSAB_SUBDID_ICACHE; // same unit number on another device
						bus_resp.data = 64'hbad0_bad0_bad0_bad0;
						@(negedge clk);
					end
					beat_addr = {1'b0, r.addr} + 32'(b * 8);
					bus_resp_valid = 1'b1;
					bus_resp.did = FSAB_DID_CPU;
					bus_resp.subdid = FSAB_SUBDID_ICACHE;
					bus_resp.data = {beat_addr, ~beat_addr};
					@(negedge clk);
				end
				bus_resp_valid = 1'b0;
				if (withhold)
					held++;
				else
					bus_credit = 1'b1; // credit follows the last beat by one cycle
			end
		end
	end

	task automatic start_fetch(input logic [31:0] addr, input logic hit_expected);
		rd_req = 1'b1;
		rd_addr = addr;
		cur_addr = addr;
		expect_hit = hit_expected;
		first_cycle = 1'b1;
		req_base = req_total;
	endtask

	task automatic wait_accept();
		do begin
			@(negedge clk);
			first_cycle = 1'b0;
		end while (!accepted_q);
	endtask

	task automatic fetch(input logic [31:0] addr, input logic hit_expected);
		start_fetch(addr, hit_expected);
		wait_accept();
	endtask

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("timeout: a fetch was never accepted");
	end

	initial begin : stimulus
		rst_b = 1'b0;
		rd_req = 1'b0;
		rd_addr = '0;
		cur_addr = '0;
		expect_hit = 1'b0;
		first_cycle = 1'b0;
		expect_stall = 1'b0;
		withhold = 1'b0;
		req_base = '0;
		repeat (4) @(negedge clk);
		rst_b = 1'b1;
		@(negedge clk);
		fetch(LINE_X + 32'h08, 1'b0); // cold miss
		fetch(LINE_X + 32'h08, 1'b1);
		fetch(LINE_X + 32'h04, 1'b1);
		fetch(LINE_X + 32'h3c, 1'b1);
		rd_req = 1'b0;
		repeat (3) @(negedge clk);
		fetch(LINE_A, 1'b0);          // way 0 of set 1
		fetch(LINE_B + 32'h04, 1'b0); // way 1 of set 1
		fetch(LINE_C + 32'h08, 1'b0); // evicts A from way 0
		fetch(LINE_B + 32'h20, 1'b1);
		fetch(LINE_A + 32'h14, 1'b0); // evicts B from way 1
		withhold = 1'b1;
		fetch(LINE_D, 1'b0);
		fetch(LINE_E + 32'h30, 1'b0); // last credit is gone after this one
		start_fetch(LINE_F + 32'h2c, 1'b0);
		expect_stall = 1'b1;
		repeat (20) begin
			@(negedge clk);
			first_cycle = 1'b0;
		end
		expect_stall = 1'b0;
		withhold = 1'b0;              // credits now trickle back
		wait_accept();
		fetch(LINE_F + 32'h2c, 1'b1);
		for (int i = 0; i < 8; i++)
			fetch(LINE_A + 32'((i * 28) % 64), 1'b1); // scattered words of a resident line
		rd_req = 1'b0;
		repeat (3) @(negedge clk);
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== src.f ====
fsab_pkg.sv
icache_tags.sv
icache_data.sv
icache_miss.sv
icache_top.sv
tb_icache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the instruction cache testbench with verilator, run it, check the log

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_icache \
	-Mdir "$build_dir" -o sim_icache
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/sim_icache" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "Testbench passed" "$log_file"; then
	exit 0
fi
echo "pass line not found in $log_file"
exit 1
